// ==== design/conv_pkg.sv ====
package conv_pkg;

    // Signed fixed point, 16 fraction bits
    localparam int VALUE_BITS = 32;
    localparam int FRAC_BITS = 16;

    // Square kernel side
    localparam int KERNEL_SIZE = 3;

    // One pixel, weight or bias value
    typedef logic signed [VALUE_BITS-1:0] pixel_t;

    // Indexed [row][col]
    // Row 0 is the oldest image row, column 0 the leftmost pixel
    typedef pixel_t [KERNEL_SIZE-1:0][KERNEL_SIZE-1:0] window_t;

    // Kernel weights, same indexing as the window
    typedef pixel_t [KERNEL_SIZE-1:0][KERNEL_SIZE-1:0] kernel_t;

    // Window beat passed from the line buffer to the MAC stage
    typedef struct packed {
        window_t win;
        // High on the final window of an image
        logic    last;
    } win_beat_t;

endpackage

// ==== design/line_ram.sv ====
`timescale 1ns/100ps

module line_ram import conv_pkg::*; #(
    parameter int IMG_WIDTH = 8
) (
    input  logic                         clk,
    input  logic                         i_w_en,
    input  logic [$clog2(IMG_WIDTH)-1:0] i_w_addr,
    input  pixel_t                       i_w_data,
    input  logic [$clog2(IMG_WIDTH)-1:0] i_r_addr,
    output pixel_t                       o_r_data
);

    // One image row
    pixel_t mem [IMG_WIDTH];

    // Registered read, data follows the address by one cycle
    always_ff @(posedge clk) begin
        if (i_w_en) begin
            mem[i_w_addr] <= i_w_data;
        end
        o_r_data <= mem[i_r_addr];
    end

endmodule

// ==== design/window_gen.sv ====
`timescale 1ns/100ps

module window_gen import conv_pkg::*; #(
    parameter int IMG_WIDTH = 8
) (
    input  logic      clk,
    input  logic      reset,
    // Pixel stream
    input  pixel_t    i_pixel,
    input  logic      i_valid,
    input  logic      i_last,
    output logic      o_ready,
    // Window stream
    output win_beat_t o_win,
    output logic      o_win_valid,
    input  logic      i_win_ready
);

    localparam int AW = $clog2(IMG_WIDTH);
    localparam int ROWS_BUFFERED = KERNEL_SIZE - 1;

    // Column and row position of the next pixel
    logic [AW-1:0] col_q;
    logic [1:0]    row_q;
    // RAM holding the oldest row, overwritten by the incoming row
    logic          sel_q;

    logic [AW-1:0] next_col;
    logic [AW-1:0] rd_addr;
    pixel_t        rd_data [ROWS_BUFFERED];

    // Window shift register and its flags
    window_t       taps_q;
    logic          win_valid_q;
    logic          win_last_q;

    logic          accept;
    logic          row_end;
    logic          win_new;
    pixel_t        new_col [KERNEL_SIZE];

    // Pixel and window move together, so the window register must be free or leaving
    // The last window blocks the next image until it is taken
    assign o_ready = win_valid_q ? (i_win_ready && !win_last_q) : 1'b1;
    assign accept = i_valid && o_ready;
    assign row_end = (col_q == AW'(IMG_WIDTH - 1));

    // Window exists once the third row runs and three columns are in
    assign win_new = (row_q == 2'(ROWS_BUFFERED)) && (col_q >= AW'(KERNEL_SIZE - 1));

    always_comb begin
        next_col = col_q;
        if (accept) begin
            next_col = (row_end || i_last) ? '0 : col_q + 1'b1;
        end
    end

    // Read ahead at the column about to be consumed
    // The old row value is read before this column is overwritten
    assign rd_addr = next_col;

    for (genvar k = 0; k < ROWS_BUFFERED; k++) begin : g_rows
        line_ram #(
            .IMG_WIDTH(IMG_WIDTH)
        ) u_line_ram (
            .clk      (clk),
            .i_w_en   (accept && (sel_q == 1'(k))),
            .i_w_addr (col_q),
            .i_w_data (i_pixel),
            .i_r_addr (rd_addr),
            .o_r_data (rd_data[k])
        );
    end

    // Rotate RAM outputs into age order, newest row comes straight from the input
    always_comb begin
        new_col[0] = sel_q ? rd_data[1] : rd_data[0];
        new_col[1] = sel_q ? rd_data[0] : rd_data[1];
        new_col[2] = i_pixel;
    end

    // Position counters
    always_ff @(posedge clk) begin
        if (reset) begin
            col_q <= '0;
            row_q <= '0;
            sel_q <= 1'b0;
        end else if (accept) begin
            col_q <= next_col;
            if (i_last) begin
                // Restart for the next image
                row_q <= '0;
                sel_q <= 1'b0;
            end else if (row_end) begin
                sel_q <= ~sel_q;
                if (row_q != 2'(ROWS_BUFFERED)) begin
                    row_q <= row_q + 1'b1;
                end
            end
        end
    end

    // Shift every row left by one column per consumed pixel
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int r = 0; r < KERNEL_SIZE; r++) begin
                for (int c = 0; c < KERNEL_SIZE - 1; c++) begin
                    taps_q[r][c] <= taps_q[r][c+1];
                end
                taps_q[r][KERNEL_SIZE-1] <= new_col[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid_q <= 1'b0;
            win_last_q <= 1'b0;
        end else if (accept) begin
            win_valid_q <= win_new;
            win_last_q <= i_last && win_new;
        end else if (i_win_ready) begin
            // Window taken with no pixel to replace it
            win_valid_q <= 1'b0;
            win_last_q <= 1'b0;
        end
    end

    assign o_win = '{win: taps_q, last: win_last_q};
    assign o_win_valid = win_valid_q;

endmodule

// ==== design/channel_mac.sv ====
`timescale 1ns/100ps

module channel_mac import conv_pkg::*; #(
    parameter int OUT_CHANNELS = 2
) (
    input  logic                           clk,
    input  logic                           reset,
    // Window stream
    input  win_beat_t                      i_win,
    input  logic                           i_win_valid,
    output logic                           o_win_ready,
    // Weights, one kernel per output channel
    input  kernel_t [OUT_CHANNELS-1:0]     i_weights,
    // Raw sums stream
    output pixel_t  [OUT_CHANNELS-1:0]     o_sums,
    output logic                           o_sum_valid,
    output logic                           o_sum_last,
    input  logic                           i_sum_ready
);

    localparam int CW = $clog2(OUT_CHANNELS + 1);
    localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;

    // Held window
    window_t                       win_q;
    logic                          last_q;
    logic                          busy_q;

    // Channel being computed, OUT_CHANNELS means all done
    logic [CW-1:0]                 ch_q;
    // 0 forms products, 1 sums them
    logic                          phase_q;
    logic                          sum_valid_q;

    logic signed [2*VALUE_BITS-1:0] prod_q [TAPS];
    pixel_t                        chan_sum;
    pixel_t  [OUT_CHANNELS-1:0]    sums_q;

    assign o_win_ready = !busy_q;

    // Realign each product and add with 32 bit wraparound
    always_comb begin
        chan_sum = '0;
        for (int k = 0; k < TAPS; k++) begin
            chan_sum = chan_sum + pixel_t'(prod_q[k][FRAC_BITS +: VALUE_BITS]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            last_q <= 1'b0;
            ch_q <= '0;
            phase_q <= 1'b0;
            sum_valid_q <= 1'b0;
        end else if (!busy_q) begin
            if (i_win_valid) begin
                busy_q <= 1'b1;
                last_q <= i_win.last;
                ch_q <= '0;
                phase_q <= 1'b0;
            end
        end else if (sum_valid_q) begin
            // Hold the result until it is taken
            if (i_sum_ready) begin
                sum_valid_q <= 1'b0;
                busy_q <= 1'b0;
            end
        end else if (ch_q == CW'(OUT_CHANNELS)) begin
            sum_valid_q <= 1'b1;
        end else begin
            phase_q <= ~phase_q;
            if (phase_q) begin
                ch_q <= ch_q + 1'b1;
            end
        end
    end

    // Datapath, two cycles per channel
    always_ff @(posedge clk) begin
        if (!busy_q && i_win_valid) begin
            win_q <= i_win.win;
        end
        if (busy_q && !sum_valid_q && ch_q != CW'(OUT_CHANNELS)) begin
            if (!phase_q) begin
                for (int r = 0; r < KERNEL_SIZE; r++) begin
                    for (int c = 0; c < KERNEL_SIZE; c++) begin
                        prod_q[r*KERNEL_SIZE + c] <=
                            $signed(i_weights[ch_q][r][c]) * $signed(win_q[r][c]);
                    end
                end
            end else begin
                sums_q[ch_q] <= chan_sum;
            end
        end
    end

    assign o_sums = sums_q;
    assign o_sum_valid = sum_valid_q;
    assign o_sum_last = last_q;

endmodule

// ==== design/bias_relu_out.sv ====
`timescale 1ns/100ps

module bias_relu_out import conv_pkg::*; #(
    parameter int OUT_CHANNELS = 2,
    parameter int USE_RELU = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    // Raw sums from the MAC stage
    input  pixel_t [OUT_CHANNELS-1:0]  i_sums,
    input  logic                       i_sum_valid,
    input  logic                       i_sum_last,
    output logic                       o_sum_ready,
    // Per channel bias
    input  pixel_t [OUT_CHANNELS-1:0]  i_bias,
    // Result stream
    output pixel_t [OUT_CHANNELS-1:0]  o_result,
    output logic                       o_valid,
    output logic                       o_last,
    input  logic                       i_ready
);

    pixel_t [OUT_CHANNELS-1:0] next_result;
    pixel_t [OUT_CHANNELS-1:0] result_q;
    logic                      valid_q;
    logic                      last_q;

    // Take a new result when empty or being drained
    assign o_sum_ready = !valid_q || i_ready;

    always_comb begin
        for (int ch = 0; ch < OUT_CHANNELS; ch++) begin
            next_result[ch] = i_sums[ch] + i_bias[ch];
            // Negative values clamp to zero when ReLU is on
            if (USE_RELU != 0 && next_result[ch][VALUE_BITS-1]) begin
                next_result[ch] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            last_q <= 1'b0;
        end else if (o_sum_ready) begin
            valid_q <= i_sum_valid;
            last_q <= i_sum_valid && i_sum_last;
        end
    end

    always_ff @(posedge clk) begin
        if (o_sum_ready && i_sum_valid) begin
            result_q <= next_result;
        end
    end

    assign o_result = result_q;
    assign o_valid = valid_q;
    assign o_last = last_q;

endmodule

// ==== design/conv2d_top.sv ====
`timescale 1ns/100ps

module conv2d_top import conv_pkg::*; #(
    parameter int IMG_WIDTH = 8,
    parameter int OUT_CHANNELS = 2,
    parameter int USE_RELU = 1
) (
    input  logic                        clk,
    input  logic                        reset,
    // Pixel input
    input  pixel_t                      i_pixel,
    input  logic                        i_valid,
    input  logic                        i_last,
    output logic                        o_ready,
    // Static configuration during an image
    input  kernel_t [OUT_CHANNELS-1:0]  i_weights,
    input  pixel_t  [OUT_CHANNELS-1:0]  i_bias,
    // Result output
    output pixel_t  [OUT_CHANNELS-1:0]  o_result,
    output logic                        o_valid,
    output logic                        o_last,
    input  logic                        i_ready
);

    // Line buffer to MAC
    win_beat_t                 win_beat;
    logic                      win_valid;
    logic                      win_ready;

    // MAC to output stage
    pixel_t [OUT_CHANNELS-1:0] sums;
    logic                      sum_valid;
    logic                      sum_last;
    logic                      sum_ready;

    window_gen #(
        .IMG_WIDTH(IMG_WIDTH)
    ) u_window_gen (
        .clk         (clk),
        .reset       (reset),
        .i_pixel     (i_pixel),
        .i_valid     (i_valid),
        .i_last      (i_last),
        .o_ready     (o_ready),
        .o_win       (win_beat),
        .o_win_valid (win_valid),
        .i_win_ready (win_ready)
    );

    channel_mac #(
        .OUT_CHANNELS(OUT_CHANNELS)
    ) u_channel_mac (
        .clk         (clk),
        .reset       (reset),
        .i_win       (win_beat),
        .i_win_valid (win_valid),
        .o_win_ready (win_ready),
        .i_weights   (i_weights),
        .o_sums      (sums),
        .o_sum_valid (sum_valid),
        .o_sum_last  (sum_last),
        .i_sum_ready (sum_ready)
    );

    bias_relu_out #(
        .OUT_CHANNELS(OUT_CHANNELS),
        .USE_RELU(USE_RELU)
    ) u_bias_relu_out (
        .clk         (clk),
        .reset       (reset),
        .i_sums      (sums),
        .i_sum_valid (sum_valid),
        .i_sum_last  (sum_last),
        .o_sum_ready (sum_ready),
        .i_bias      (i_bias),
        .o_result    (o_result),
        .o_valid     (o_valid),
        .o_last      (o_last),
        .i_ready     (i_ready)
    );

endmodule

// ==== test/conv2d_props.sv ====
`timescale 1ns/100ps

module conv2d_props import conv_pkg::*; #(
    parameter int OUT_CHANNELS = 2
) (
    input  logic                       clk,
    input  logic                       reset,
    input  pixel_t [OUT_CHANNELS-1:0]  o_result,
    input  logic                       o_valid,
    input  logic                       o_last,
    input  logic                       i_ready
);

    // Output beat held steady while the sink stalls
    a_hold_output: assert property (@(posedge clk) disable iff (reset)
        o_valid && !i_ready |=> o_valid && $stable(o_result))
        else $error("o_valid or o_result changed while i_ready was low");

    // Last flag only rides on a valid beat
    a_last_needs_valid: assert property (@(posedge clk) disable iff (reset)
        o_last |-> o_valid)
        else $error("o_last high without o_valid");

    // Output stage comes out of reset empty
    a_reset_clears_valid: assert property (@(posedge clk)
        reset |=> !o_valid)
        else $error("o_valid high in the cycle after reset");

endmodule

bind conv2d_top conv2d_props #(
    .OUT_CHANNELS(OUT_CHANNELS)
) u_conv2d_props (
    .clk      (clk),
    .reset    (reset),
    .o_result (o_result),
    .o_valid  (o_valid),
    .o_last   (o_last),
    .i_ready  (i_ready)
);

// ==== test/conv2d_tb.sv ====
`timescale 1ns/100ps

module conv2d_tb
    import conv_pkg::*;
();

    localparam int IMG_WIDTH = 8;
    localparam int IMG_HEIGHT = 5;
    localparam int OUT_CHANNELS = 2;
    localparam int USE_RELU = 1;
    localparam int RESULTS_PER_IMAGE = (IMG_HEIGHT - 2) * (IMG_WIDTH - 2);
    localparam int NUM_TESTS = 4;
    localparam logic [31:0] LFSR_SEED = 32'hc44f_2184;

    typedef pixel_t [OUT_CHANNELS-1:0] result_t;

    // One row per test with bias alternating between even and odd channels
    typedef struct {
        string  name;
        bit     rand_pix;
        bit     rand_wt;
        pixel_t bias_even;
        pixel_t bias_odd;
        bit     stall;
        bit     reseed;
        int     images;
    } test_row_t;

    // Rows 2 and 3 reseed so that both see the same image and weights
    test_row_t tests [NUM_TESTS] = '{
        '{"ramp, unit weights", 1'b0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 1},
        '{"random, signed bias", 1'b1, 1'b1, 32'hfffe_0000, 32'h0003_8000, 1'b0, 1'b1, 1},
        '{"random, back-pressure", 1'b1, 1'b1, 32'hfffe_0000, 32'h0003_8000, 1'b1, 1'b1, 1},
        '{"two images", 1'b1, 1'b1, 32'h0000_4000, 32'hffff_0000, 1'b0, 1'b0, 2}
    };

    logic                       clk;
    logic                       reset;
    pixel_t                     i_pixel;
    logic                       i_valid;
    logic                       i_last;
    logic                       o_ready;
    kernel_t [OUT_CHANNELS-1:0] i_weights;
    result_t                    i_bias;
    result_t                    o_result;
    logic                       o_valid;
    logic                       o_last;
    logic                       i_ready;

    logic [31:0] lfsr_state;
    pixel_t      img [IMG_HEIGHT][IMG_WIDTH];
    // Pixel stream and expected results for the running test
    pixel_t      pix_q [$];
    bit          pix_last_q [$];
    result_t     exp_q [$];
    bit          exp_last_q [$];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    bit          held_seen;

    conv2d_top #(
        .IMG_WIDTH(IMG_WIDTH),
        .OUT_CHANNELS(OUT_CHANNELS),
        .USE_RELU(USE_RELU)
    ) u_conv2d_top (
        .clk       (clk),
        .reset     (reset),
        .i_pixel   (i_pixel),
        .i_valid   (i_valid),
        .i_last    (i_last),
        .o_ready   (o_ready),
        .i_weights (i_weights),
        .i_bias    (i_bias),
        .o_result  (o_result),
        .o_valid   (o_valid),
        .o_last    (o_last),
        .i_ready   (i_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit in cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, results stopped arriving", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Sign extended value of n random bits
    function automatic pixel_t rand_signed(input int n);
        pixel_t v;
        v = pixel_t'(rand_bits(n) << (32 - n));
        return v >>> (32 - n);
    endfunction

    // Four cycles per pixel plus a full MAC pass per result
    function automatic int timeout_limit();
        int pixels;
        int results;
        pixels = 0;
        results = 0;
        foreach (tests[i]) begin
            pixels += tests[i].images * IMG_HEIGHT * IMG_WIDTH;
            results += tests[i].images * RESULTS_PER_IMAGE;
        end
        return 4 * pixels + results * (2 * OUT_CHANNELS + 2) + 200;
    endfunction

    // Reference model for the window whose top left pixel sits at row r and column k
    function automatic result_t expected_at(input int r, input int k);
        result_t            res;
        logic signed [63:0] a64;
        logic signed [63:0] b64;
        logic signed [63:0] prod;
        pixel_t             acc;
        for (int ch = 0; ch < OUT_CHANNELS; ch++) begin
            acc = '0;
            for (int dr = 0; dr < KERNEL_SIZE; dr++) begin
                for (int dc = 0; dc < KERNEL_SIZE; dc++) begin
                    // Full 64 bit product
                    a64 = 64'(img[r+dr][k+dc]);
                    b64 = 64'($signed(i_weights[ch][dr][dc]));
                    prod = a64 * b64;
                    // Realign to 16 fraction bits and wrap at 32 bits
                    acc = acc + prod[FRAC_BITS +: VALUE_BITS];
                end
            end
            acc = acc + i_bias[ch];
            // Negative results clamp to zero
            if (USE_RELU != 0 && acc < 0) begin
                acc = '0;
            end
            res[ch] = acc;
        end
        return res;
    endfunction

    // Sets weights and bias and builds the pixel stream and expected results
    task automatic prepare_test(input test_row_t t);
        if (t.reseed) begin
            lfsr_state = LFSR_SEED;
        end
        for (int ch = 0; ch < OUT_CHANNELS; ch++) begin
            for (int dr = 0; dr < KERNEL_SIZE; dr++) begin
                for (int dc = 0; dc < KERNEL_SIZE; dc++) begin
                    i_weights[ch][dr][dc] = t.rand_wt ? rand_signed(18)
                                                      : pixel_t'(32'h0001_0000);
                end
            end
            i_bias[ch] = (ch % 2 == 0) ? t.bias_even : t.bias_odd;
        end
        for (int n = 0; n < t.images; n++) begin
            for (int r = 0; r < IMG_HEIGHT; r++) begin
                for (int c = 0; c < IMG_WIDTH; c++) begin
                    // Ramp holds whole numbers offset per image
                    img[r][c] = t.rand_pix ? rand_signed(20)
                                           : pixel_t'((r * IMG_WIDTH + c + n * 5) << FRAC_BITS);
                    pix_q.push_back(img[r][c]);
                    pix_last_q.push_back(r == IMG_HEIGHT - 1 && c == IMG_WIDTH - 1);
                end
            end
            // Windows in raster order, last one flagged
            for (int r = 0; r < IMG_HEIGHT - 2; r++) begin
                for (int k = 0; k < IMG_WIDTH - 2; k++) begin
                    exp_q.push_back(expected_at(r, k));
                    exp_last_q.push_back(r == IMG_HEIGHT - 3 && k == IMG_WIDTH - 3);
                end
            end
        end
    endtask

    // One pixel per cycle held until o_ready
    task automatic drive_pixels();
        while (pix_q.size() > 0) begin
            @(negedge clk);
            i_valid = 1'b1;
            i_pixel = pix_q[0];
            i_last = pix_last_q[0];
            #1;
            if (o_ready) begin
                void'(pix_q.pop_front());
                void'(pix_last_q.pop_front());
            end
        end
        @(negedge clk);
        i_valid = 1'b0;
        i_last = 1'b0;
    endtask

    // Sets i_ready each cycle and checks every output transfer
    task automatic collect_results(input int count, input bit stall);
        int          got;
        logic [31:0] gap;
        result_t     exp_res;
        bit          exp_last;
        got = 0;
        while (got < count) begin
            @(negedge clk);
            gap = stall ? rand_bits(1) : 32'h1;
            i_ready = gap[0];
            #1;
            // Output stalled and the input side backed up
            if (o_valid && !i_ready && !o_ready) begin
                held_seen = 1'b1;
            end
            if (o_valid && i_ready) begin
                exp_res = exp_q.pop_front();
                exp_last = exp_last_q.pop_front();
                for (int ch = 0; ch < OUT_CHANNELS; ch++) begin
                    checks++;
                    if (o_result[ch] !== exp_res[ch]) begin
                        $display("[FAIL] o_result[%0d] at result %0d: got %h, expected %h",
                                 ch, got, o_result[ch], exp_res[ch]);
                        errors++;
                    end
                end
                checks++;
                if (o_last !== exp_last) begin
                    $display("[FAIL] o_last at result %0d: got %h, expected %h",
                             got, o_last, exp_last);
                    errors++;
                end
                got++;
            end
        end
    endtask

    task automatic run_test(input int idx);
        test_row_t t;
        int        count;
        int        errors_before;
        t = tests[idx];
        errors_before = errors;
        held_seen = 1'b0;
        @(negedge clk);
        prepare_test(t);
        count = exp_q.size();
        fork
            drive_pixels();
            collect_results(count, t.stall);
        join
        // Back-pressure has to reach the pixel input
        if (t.stall) begin
            checks++;
            if (!held_seen) begin
                $display("o_ready never fell while the output was held under back-pressure");
                errors++;
            end
        end
        // Nothing beyond the expected count
        repeat (2 * OUT_CHANNELS + 4) begin
            @(negedge clk);
            i_ready = 1'b1;
            #1;
            checks++;
            if (o_valid) begin
                $display("Extra result after the expected %0d results", count);
                errors++;
            end
        end
        $display("Test %0d (%s): %0d results, %0d errors",
                 idx + 1, t.name, count, errors - errors_before);
    endtask

    initial begin
        cycle_limit = timeout_limit();
        reset = 1'b1;
        i_pixel = '0;
        i_valid = 1'b0;
        i_last = 1'b0;
        i_weights = '0;
        i_bias = '0;
        i_ready = 1'b1;
        lfsr_state = LFSR_SEED;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        // Idle state right after reset
        checks += 3;
        if (o_valid !== 1'b0) begin
            $display("[FAIL] o_valid after reset: got %h, expected 0", o_valid);
            errors++;
        end
        if (o_last !== 1'b0) begin
            $display("[FAIL] o_last after reset: got %h, expected 0", o_last);
            errors++;
        end
        if (o_ready !== 1'b1) begin
            $display("[FAIL] o_ready after reset: got %h, expected 1", o_ready);
            errors++;
        end
        $display("Test 0 (reset state): %0d errors", errors);
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS + 1, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
design/conv_pkg.sv
design/line_ram.sv
design/window_gen.sv
design/channel_mac.sv
design/bias_relu_out.sv
design/conv2d_top.sv
test/conv2d_props.sv
test/conv2d_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := conv2d_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_TEXT := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
